//--- design/channel_stats.sv
`timescale 1ns/100ps

module channel_stats (
    input  logic                clk,
    input  logic                i_reset,
    input  wb_pkg::video_beat_t i_beat,
    output wb_pkg::rgb_t        o_avg,
    output logic [7:0]          o_k,
    output logic                o_stats_valid
);

    import wb_pkg::*;

    logic [SUM_W-1:0] cur_r_q;
    logic [SUM_W-1:0] cur_g_q;
    logic [SUM_W-1:0] cur_b_q;
    logic [SUM_W-1:0] last_r_q;
    logic [SUM_W-1:0] last_g_q;
    logic [SUM_W-1:0] last_b_q;
    logic [9:0]       avg_sum;
    logic             vsync_d_q;

    // running sums of the frame in progress, handed over on vsync.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            cur_r_q  <= '0;
            cur_g_q  <= '0;
            cur_b_q  <= '0;
            last_r_q <= '0;
            last_g_q <= '0;
            last_b_q <= '0;
        end else if (i_beat.vsync) begin
            cur_r_q  <= '0;
            cur_g_q  <= '0;
            cur_b_q  <= '0;
            last_r_q <= cur_r_q;
            last_g_q <= cur_g_q;
            last_b_q <= cur_b_q;
        end else if (i_beat.href) begin
            cur_r_q <= cur_r_q + SUM_W'(i_beat.pix.r);
            cur_g_q <= cur_g_q + SUM_W'(i_beat.pix.g);
            cur_b_q <= cur_b_q + SUM_W'(i_beat.pix.b);
        end
    end

    // average is the sum divided by the pixel count.
    assign o_avg.r = last_r_q[SUM_W-1:TRIM_BITS];
    assign o_avg.g = last_g_q[SUM_W-1:TRIM_BITS];
    assign o_avg.b = last_b_q[SUM_W-1:TRIM_BITS];

    assign avg_sum = 10'(o_avg.r) + 10'(o_avg.g) + 10'(o_avg.b);

    // k and the valid pulse land one cycle after the transfer.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            vsync_d_q     <= 1'b0;
            o_stats_valid <= 1'b0;
            o_k           <= '0;
        end else begin
            vsync_d_q     <= i_beat.vsync;
            o_stats_valid <= vsync_d_q;
            o_k           <= 8'(avg_sum / 10'd3);
        end
    end

endmodule : channel_stats

//--- design/gain_apply.sv
`timescale 1ns/100ps

module gain_apply (
    input  logic           clk,
    input  logic           i_reset,
    input  wb_pkg::rgb_t   i_pix,
    input  wb_pkg::gains_t i_gains,
    output wb_pkg::rgb_t   o_pix
);

    import wb_pkg::*;

    logic [GAIN_W+7:0] prod_r_q;
    logic [GAIN_W+7:0] prod_g_q;
    logic [GAIN_W+7:0] prod_b_q;

    // drop the fraction bits and saturate at 255.
    function automatic logic [7:0] clamp8(input logic [GAIN_W+7:0] prod);
        logic [GAIN_W+7-GAIN_FRAC:0] whole;
        whole = prod[GAIN_W+7:GAIN_FRAC];
        if (whole > 'd255) begin
            return 8'hff;
        end
        return whole[7:0];
    endfunction

    // stage 1 is the multiply.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            prod_r_q <= '0;
            prod_g_q <= '0;
            prod_b_q <= '0;
        end else begin
            prod_r_q <= i_pix.r * i_gains.r;
            prod_g_q <= i_pix.g * i_gains.g;
            prod_b_q <= i_pix.b * i_gains.b;
        end
    end

    // stage 2 is the shift and clamp.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_pix <= '0;
        end else begin
            o_pix.r <= clamp8(prod_r_q);
            o_pix.g <= clamp8(prod_g_q);
            o_pix.b <= clamp8(prod_b_q);
        end
    end

endmodule : gain_apply

//--- design/gain_divider.sv
`timescale 1ns/100ps

module gain_divider (
    input  logic                      clk,
    input  logic                      i_reset,
    input  logic                      i_start,
    input  logic [wb_pkg::GAIN_W-1:0] i_num,
    input  logic [7:0]                i_den,
    output logic [wb_pkg::GAIN_W-1:0] o_quot,
    output logic                      o_done
);

    import wb_pkg::*;

    logic [GAIN_W-1:0]            num_q;
    logic [GAIN_W-1:0]            quot_q;
    logic [7:0]                   den_q;
    logic [7:0]                   rem_q;
    logic [$clog2(GAIN_W+1)-1:0] cnt_q;
    logic                         busy_q;
    logic [8:0]                   rem_shift;
    logic [9:0]                   diff;

    // bring down the next numerator bit and try the subtraction.
    assign rem_shift = {rem_q, num_q[GAIN_W-1]};
    assign diff      = {1'b0, rem_shift} - {2'b00, den_q};

    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (!busy_q && i_start) begin
                busy_q <= 1'b1;
                cnt_q  <= ($clog2(GAIN_W+1))'(GAIN_W);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == 1) begin
                    busy_q <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    // one quotient bit per cycle, msb first.
    always_ff @(posedge clk) begin
        if (!busy_q && i_start) begin
            num_q  <= i_num;
            den_q  <= i_den;
            rem_q  <= '0;
            quot_q <= '0;
        end else if (busy_q) begin
            num_q <= num_q << 1;
            if (!diff[9]) begin
                rem_q  <= diff[7:0];
                quot_q <= {quot_q[GAIN_W-2:0], 1'b1};
            end else begin
                rem_q  <= rem_shift[7:0];
                quot_q <= {quot_q[GAIN_W-2:0], 1'b0};
            end
        end
    end

    assign o_quot = quot_q;

endmodule : gain_divider

//--- design/gain_table.sv
`timescale 1ns/100ps

module gain_table (
    input  logic           clk,
    input  logic           i_reset,
    input  logic           i_stats_valid,
    input  wb_pkg::rgb_t   i_avg,
    input  logic [7:0]     i_k,
    output wb_pkg::gains_t o_gains
);

    import wb_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT, S_COMMIT} state_e;

    state_e            state_q;
    logic [1:0]        ch_q;
    rgb_t              avg_q;
    logic [GAIN_W-1:0] num_q;
    gains_t            shadow_q;
    logic [7:0]        cur_avg;
    logic              div_start;
    logic              div_done;
    logic [GAIN_W-1:0] div_quot;
    logic              shadow_we;
    logic [GAIN_W-1:0] gain_result;

    always_comb begin
        case (ch_q)
            2'd0:    cur_avg = avg_q.r;
            2'd1:    cur_avg = avg_q.g;
            default: cur_avg = avg_q.b;
        endcase
    end

    // a zero average skips the divider and keeps unity.
    assign div_start   = (state_q == S_ISSUE) && (cur_avg != 8'd0);
    assign shadow_we   = ((state_q == S_ISSUE) && (cur_avg == 8'd0))
                      || ((state_q == S_WAIT) && div_done);
    assign gain_result = (state_q == S_ISSUE) ? UNITY_GAIN : div_quot;

    gain_divider u_gain_divider (
        .clk    (clk),
        .i_reset(i_reset),
        .i_start(div_start),
        .i_num  (num_q),
        .i_den  (cur_avg),
        .o_quot (div_quot),
        .o_done (div_done)
    );

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q <= S_IDLE;
            ch_q    <= '0;
            o_gains <= '{r: UNITY_GAIN, g: UNITY_GAIN, b: UNITY_GAIN};
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (i_stats_valid) begin
                        ch_q    <= '0;
                        state_q <= S_ISSUE;
                    end
                end
                S_ISSUE:  state_q <= S_WAIT;
                S_WAIT:   state_q <= S_WAIT;
                S_COMMIT: begin
                    // all three gains switch in the same cycle.
                    o_gains <= shadow_q;
                    state_q <= S_IDLE;
                end
                default:  state_q <= S_IDLE;
            endcase
            if (shadow_we) begin
                if (ch_q == 2'd2) begin
                    state_q <= S_COMMIT;
                end else begin
                    ch_q    <= ch_q + 2'd1;
                    state_q <= S_ISSUE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && i_stats_valid) begin
            avg_q <= i_avg;
            num_q <= GAIN_W'(i_k) << GAIN_FRAC;
        end
        if (shadow_we) begin
            case (ch_q)
                2'd0:    shadow_q.r <= gain_result;
                2'd1:    shadow_q.g <= gain_result;
                default: shadow_q.b <= gain_result;
            endcase
        end
    end

endmodule : gain_table

//--- design/sync_delay.sv
`timescale 1ns/100ps

module sync_delay (
    input  logic                clk,
    input  logic                i_reset,
    input  wb_pkg::video_beat_t i_beat,
    output wb_pkg::video_beat_t o_beat
);

    import wb_pkg::*;

    video_beat_t stage_q [PIPE_DEPTH];

    always_ff @(posedge clk) begin
        stage_q[0] <= i_beat;
        for (int i = 1; i < PIPE_DEPTH; i++) begin
            stage_q[i] <= stage_q[i-1];
        end
        // only the flags are cleared, pixel and coordinates just pass.
        if (i_reset) begin
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                stage_q[i].vsync <= 1'b0;
                stage_q[i].hsync <= 1'b0;
                stage_q[i].href  <= 1'b0;
                stage_q[i].de    <= 1'b0;
            end
        end
    end

    assign o_beat = stage_q[PIPE_DEPTH-1];

endmodule : sync_delay

//--- design/wb_pkg.sv
package wb_pkg;

    // frame geometry of the active window.
    localparam int H_ACT       = 16;
    localparam int V_ACT       = 8;
    localparam int FRAME_TOTAL = H_ACT * V_ACT;

    // averages come from a plain shift, so FRAME_TOTAL has to be a power of two.
    localparam int TRIM_BITS = $clog2(FRAME_TOTAL);
    localparam int SUM_W     = $clog2(FRAME_TOTAL * 255 + 1);

    // gains are unsigned fixed point with GAIN_FRAC fraction bits.
    localparam int GAIN_FRAC = 16;
    localparam int GAIN_W    = 24;

    localparam logic [GAIN_W-1:0] UNITY_GAIN = GAIN_W'(1) << GAIN_FRAC;

    // cycles from i_beat to o_beat.
    localparam int PIPE_DEPTH = 2;

    localparam int X_W = $clog2(H_ACT);
    localparam int Y_W = $clog2(V_ACT);

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic [GAIN_W-1:0] r;
        logic [GAIN_W-1:0] g;
        logic [GAIN_W-1:0] b;
    } gains_t;

    typedef struct packed {
        logic           vsync;
        logic           hsync;
        logic           href;
        logic           de;
        rgb_t           pix;
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
    } video_beat_t;

endpackage : wb_pkg

//--- design/white_balance.sv
`timescale 1ns/100ps

module white_balance (
    input  logic                clk,
    input  logic                i_reset,
    input  wb_pkg::video_beat_t i_beat,
    output wb_pkg::video_beat_t o_beat
);

    import wb_pkg::*;

    rgb_t        avg;
    logic [7:0]  k;
    logic        stats_valid;
    gains_t      gains;
    rgb_t        pix_bal;
    video_beat_t beat_dly;

    // frame statistics, closed on each vsync.
    channel_stats u_channel_stats (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_beat       (i_beat),
        .o_avg        (avg),
        .o_k          (k),
        .o_stats_valid(stats_valid)
    );

    // gains are recomputed during vertical blanking.
    gain_table u_gain_table (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_stats_valid(stats_valid),
        .i_avg        (avg),
        .i_k          (k),
        .o_gains      (gains)
    );

    gain_apply u_gain_apply (
        .clk    (clk),
        .i_reset(i_reset),
        .i_pix  (i_beat.pix),
        .i_gains(gains),
        .o_pix  (pix_bal)
    );

    // sync flags and coordinates follow the pixel latency.
    sync_delay u_sync_delay (
        .clk    (clk),
        .i_reset(i_reset),
        .i_beat (i_beat),
        .o_beat (beat_dly)
    );

    always_comb begin
        o_beat     = beat_dly;
        o_beat.pix = pix_bal;
    end

endmodule : white_balance

//--- run_sim.sh
#!/bin/sh
# Compile and run tb_white_balance with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_white_balance \
    -Mdir obj_dir -o tb_white_balance
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_white_balance > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation passed"
exit 0

//--- sim.f
design/wb_pkg.sv
design/channel_stats.sv
design/gain_divider.sv
design/gain_table.sv
design/gain_apply.sv
design/sync_delay.sv
design/white_balance.sv
verif/tb_white_balance.sv

//--- verif/tb_white_balance.sv
`timescale 1ns/100ps

module tb_white_balance;

    import wb_pkg::*;

    localparam int BLANK_CYCLES = 120;
    localparam int HBLANK_BEATS = 4;
    localparam int NUM_ROWS     = 6;
    localparam int POLL_LIMIT   = 8;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic [7:0] jitter;
        logic       clamp;
    } frame_row_t;

    logic              clk;
    logic              i_reset;
    video_beat_t       i_beat;
    video_beat_t       o_beat;
    frame_row_t        rows [NUM_ROWS];
    video_beat_t       want_q [$];
    logic [GAIN_W-1:0] cur_gain [3];
    logic [GAIN_W-1:0] next_gain [3];
    longint            sums [3];
    integer            seed;
    int                checks;
    int                errors;

    white_balance dut_i (
        .clk    (clk),
        .i_reset(i_reset),
        .i_beat (i_beat),
        .o_beat (o_beat)
    );

    always #2 clk = ~clk;

    // clk is polled on odd nanoseconds, away from both of its edges.
    task automatic next_cycle();
        int   polls;
        logic seen_low;
        polls    = 0;
        seen_low = (clk === 1'b0);
        while (polls < POLL_LIMIT && !(seen_low && clk === 1'b1)) begin
            #2;
            polls++;
            if (clk === 1'b0) begin
                seen_low = 1'b1;
            end
        end
        if (!(seen_low && clk === 1'b1)) begin
            $display("timeout: clk stopped toggling, the stream stalled at %0t", $time);
            $display("Errors found");
            $finish;
        end
    endtask

    function automatic logic [GAIN_W-1:0] gain_for(input longint avg, input longint k);
        if (avg == 0) begin
            return UNITY_GAIN;
        end
        return GAIN_W'((k << GAIN_FRAC) / avg);
    endfunction

    function automatic logic [7:0] scale_channel(input logic [7:0] pix,
                                                 input logic [GAIN_W-1:0] gain);
        longint prod;
        prod = (longint'(pix) * longint'(gain)) >> GAIN_FRAC;
        return (prod > 255) ? 8'hff : 8'(prod);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    // averages, k and the next gain set from the frame just closed.
    task automatic close_frame();
        longint avg [3];
        longint k;
        for (int c = 0; c < 3; c++) begin
            avg[c] = sums[c] >> TRIM_BITS;
        end
        k = (avg[0] + avg[1] + avg[2]) / 3;
        for (int c = 0; c < 3; c++) begin
            next_gain[c] = gain_for(avg[c], k);
            sums[c]      = 0;
        end
    endtask

    // compares the beat sent two cycles ago, then drives the next one.
    task automatic send_beat(input video_beat_t b);
        video_beat_t got;
        video_beat_t want;
        got  = o_beat;
        want = want_q.pop_front();
        check_value("o_beat.vsync", got.vsync, want.vsync);
        check_value("o_beat.hsync", got.hsync, want.hsync);
        check_value("o_beat.href", got.href, want.href);
        check_value("o_beat.de", got.de, want.de);
        check_value("o_beat.pix.r", got.pix.r, want.pix.r);
        check_value("o_beat.pix.g", got.pix.g, want.pix.g);
        check_value("o_beat.pix.b", got.pix.b, want.pix.b);
        check_value("o_beat.x", got.x, want.x);
        check_value("o_beat.y", got.y, want.y);
        i_beat     = b;
        want       = b;
        want.pix.r = scale_channel(b.pix.r, cur_gain[0]);
        want.pix.g = scale_channel(b.pix.g, cur_gain[1]);
        want.pix.b = scale_channel(b.pix.b, cur_gain[2]);
        want_q.push_back(want);
        if (b.href) begin
            sums[0] += b.pix.r;
            sums[1] += b.pix.g;
            sums[2] += b.pix.b;
        end
        next_cycle();
    endtask

    task automatic run_frame(input frame_row_t row);
        video_beat_t b;
        close_frame();
        b       = '0;
        b.vsync = 1'b1;
        send_beat(b);
        b = '0;
        for (int i = 0; i < BLANK_CYCLES; i++) begin
            send_beat(b);
        end
        // the new gains reach the first active pixel after blanking.
        cur_gain = next_gain;
        for (int y = 0; y < V_ACT; y++) begin
            for (int x = 0; x < H_ACT; x++) begin
                b       = '0;
                b.href  = 1'b1;
                b.de    = 1'b1;
                b.x     = X_W'(x);
                b.y     = Y_W'(y);
                b.pix.r = row.r + (8'($random(seed)) & row.jitter);
                b.pix.g = row.g + (8'($random(seed)) & row.jitter);
                b.pix.b = row.b + (8'($random(seed)) & row.jitter);
                if (row.clamp && (x % 4 == 0)) begin
                    b.pix = '1;
                end
                send_beat(b);
            end
            for (int h = 0; h < HBLANK_BEATS; h++) begin
                b       = '0;
                b.hsync = (h < 2);
                send_beat(b);
            end
        end
    endtask

    initial begin
        int frame_errors;
        int frame_checks;
        clk     = 1'b0;
        i_reset = 1'b1;
        i_beat  = '0;
        // flags held high during reset must not reach o_beat.
        i_beat.vsync = 1'b1;
        i_beat.hsync = 1'b1;
        i_beat.href  = 1'b1;
        i_beat.de    = 1'b1;
        seed    = 32'hbec9;
        checks  = 0;
        errors  = 0;
        // gray, then color casts, a saturating frame, a frame with no blue.
        rows[0] = '{r: 8'd100, g: 8'd100, b: 8'd100, jitter: 8'h00, clamp: 1'b0};
        rows[1] = '{r: 8'd200, g: 8'd120, b: 8'd40, jitter: 8'h0f, clamp: 1'b0};
        rows[2] = '{r: 8'd180, g: 8'd90, b: 8'd20, jitter: 8'h07, clamp: 1'b0};
        rows[3] = '{r: 8'd70, g: 8'd70, b: 8'd70, jitter: 8'h1f, clamp: 1'b1};
        rows[4] = '{r: 8'd90, g: 8'd70, b: 8'd0, jitter: 8'h00, clamp: 1'b0};
        rows[5] = '{r: 8'd50, g: 8'd50, b: 8'd50, jitter: 8'h1f, clamp: 1'b0};
        for (int c = 0; c < 3; c++) begin
            cur_gain[c]  = UNITY_GAIN;
            next_gain[c] = UNITY_GAIN;
            sums[c]      = 0;
        end
        #1;
        repeat (3) next_cycle();
        i_reset = 1'b0;
        // the first two outputs still hold the reset state.
        want_q.push_back('0);
        want_q.push_back('0);
        for (int f = 0; f < NUM_ROWS; f++) begin
            frame_errors = errors;
            frame_checks = checks;
            run_frame(rows[f]);
            $display("frame %0d: base %0d/%0d/%0d jitter 0x%0h clamp %0d, %0d checks, %0d errors",
                     f, rows[f].r, rows[f].g, rows[f].b, rows[f].jitter, rows[f].clamp,
                     checks - frame_checks, errors - frame_errors);
        end
        // two idle beats flush the pipeline.
        send_beat('0);
        send_beat('0);
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : tb_white_balance
